//--- hw/uart_config.svh
// UART timing configuration
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Clocks per bit on the line, small so simulation stays short
// A 100 MHz clock at 115200 baud would use 868
`define UART_CLKS_PER_BIT 8

// Flip-flops in the receiver input synchronizer
`define UART_SYNC_STAGES 2

`endif

//--- hw/uart_pkg.sv
// UART shared types
package uart_pkg;

    // Transmitter FSM states
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

    // Receiver FSM states
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_t;

    // One received byte and its frame status
    typedef struct packed {
        logic [7:0] data;
        logic       frame_error;  // stop bit was sampled low
    } uart_rx_word_t;

endpackage : uart_pkg

//--- hw/uart_tx.sv
// UART frame transmitter
`timescale 1ns/100ps

`include "uart_config.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic [7:0] i_tx_data,
    input  logic       i_tx_valid,
    output logic       o_tx_ready,
    output logic       o_tx
);

    localparam int COUNT_WIDTH = $clog2(CLKS_PER_BIT);
    localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(CLKS_PER_BIT - 1);

    uart_pkg::tx_state_t    r_state;
    uart_pkg::tx_state_t    w_next_state;
    logic [COUNT_WIDTH-1:0] r_clk_count;
    logic [COUNT_WIDTH-1:0] w_clk_count_next;
    logic [2:0]             r_bit_index;
    logic [2:0]             w_bit_index_next;
    logic [7:0]             r_tx_data;
    logic [7:0]             w_tx_data_next;
    logic                   w_accept;
    logic                   w_bit_done;
    logic                   r_tx;

    assign o_tx_ready = (r_state == uart_pkg::TX_IDLE);
    assign o_tx       = r_tx;
    assign w_accept   = i_tx_valid && o_tx_ready;
    assign w_bit_done = (r_clk_count == LAST_COUNT);

    // Next state, bit timer and bit index
    always_comb begin
        w_next_state     = r_state;
        w_clk_count_next = r_clk_count + 1'b1;
        w_bit_index_next = r_bit_index;
        w_tx_data_next   = r_tx_data;
        case (r_state)
            uart_pkg::TX_IDLE: begin
                w_clk_count_next = '0;
                w_bit_index_next = '0;
                if (w_accept) begin
                    w_tx_data_next = i_tx_data;
                    w_next_state   = uart_pkg::TX_START;
                end
            end
            uart_pkg::TX_START: begin
                if (w_bit_done) begin
                    w_clk_count_next = '0;
                    w_next_state     = uart_pkg::TX_DATA;
                end
            end
            uart_pkg::TX_DATA: begin
                if (w_bit_done) begin
                    w_clk_count_next = '0;
                    // Index wraps back to zero after bit 7
                    w_bit_index_next = r_bit_index + 1'b1;
                    if (r_bit_index == 3'd7) begin
                        w_next_state = uart_pkg::TX_STOP;
                    end
                end
            end
            uart_pkg::TX_STOP: begin
                if (w_bit_done) begin
                    w_clk_count_next = '0;
                    w_next_state     = uart_pkg::TX_IDLE;
                end
            end
            default: begin
                w_clk_count_next = '0;
                w_next_state     = uart_pkg::TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state     <= uart_pkg::TX_IDLE;
            r_clk_count <= '0;
            r_bit_index <= '0;
            r_tx        <= 1'b1;
        end else begin
            r_state     <= w_next_state;
            r_clk_count <= w_clk_count_next;
            r_bit_index <= w_bit_index_next;
            // Line level follows the state being entered so every bit keeps full length
            case (w_next_state)
                uart_pkg::TX_START: r_tx <= 1'b0;
                uart_pkg::TX_DATA:  r_tx <= w_tx_data_next[w_bit_index_next];
                default:            r_tx <= 1'b1;
            endcase
        end
    end

    // Byte held for the whole frame
    always_ff @(posedge i_clk) begin
        r_tx_data <= w_tx_data_next;
    end

    // Line idles high whenever a new byte can be taken
    a_idle_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_tx_ready |-> o_tx);

    // A frame in progress blocks the next byte
    a_busy_after_accept: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        w_accept |=> !o_tx_ready);

endmodule : uart_tx

//--- hw/uart_rx.sv
// UART frame receiver
`timescale 1ns/100ps

`include "uart_config.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_rx,
    output logic                    o_rx_valid,
    output uart_pkg::uart_rx_word_t o_rx_word
);

    // CLKS_PER_BIT of 4 or more, two or more sync stages
    localparam int SYNC_STAGES = `UART_SYNC_STAGES;
    localparam int COUNT_WIDTH = $clog2(CLKS_PER_BIT);
    localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(CLKS_PER_BIT - 1);
    localparam logic [COUNT_WIDTH-1:0] HALF_COUNT = COUNT_WIDTH'(CLKS_PER_BIT / 2 - 1);

    logic [SYNC_STAGES-1:0] r_sync;
    logic                   r_rx_prev;
    logic                   w_rx;
    logic                   w_fall;
    uart_pkg::rx_state_t    r_state;
    uart_pkg::rx_state_t    w_next_state;
    logic [COUNT_WIDTH-1:0] r_clk_count;
    logic [COUNT_WIDTH-1:0] w_clk_count_next;
    logic [2:0]             r_bit_index;
    logic [2:0]             w_bit_index_next;
    logic [7:0]             r_shift;
    logic                   w_data_sample;
    logic                   w_stop_sample;

    // Synchronized line and its falling edge
    assign w_rx   = r_sync[SYNC_STAGES-1];
    assign w_fall = r_rx_prev && !w_rx;

    always_comb begin
        w_next_state     = r_state;
        w_clk_count_next = r_clk_count + 1'b1;
        w_bit_index_next = r_bit_index;
        w_data_sample    = 1'b0;
        w_stop_sample    = 1'b0;
        case (r_state)
            uart_pkg::RX_IDLE: begin
                // Edge-detect cycle is the first clock of the half bit
                w_clk_count_next = COUNT_WIDTH'(1);
                w_bit_index_next = '0;
                if (w_fall) begin
                    w_next_state = uart_pkg::RX_START;
                end
            end
            uart_pkg::RX_START: begin
                if (r_clk_count == HALF_COUNT) begin
                    w_clk_count_next = '0;
                    // Line high again at mid-bit, treat as glitch
                    w_next_state = w_rx ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                end
            end
            uart_pkg::RX_DATA: begin
                if (r_clk_count == LAST_COUNT) begin
                    w_clk_count_next = '0;
                    w_data_sample    = 1'b1;
                    w_bit_index_next = r_bit_index + 1'b1;
                    if (r_bit_index == 3'd7) begin
                        w_next_state = uart_pkg::RX_STOP;
                    end
                end
            end
            uart_pkg::RX_STOP: begin
                if (r_clk_count == LAST_COUNT) begin
                    w_clk_count_next = '0;
                    w_stop_sample    = 1'b1;
                    w_next_state     = uart_pkg::RX_IDLE;
                end
            end
            default: begin
                w_clk_count_next = '0;
                w_next_state     = uart_pkg::RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_sync      <= '1;
            r_rx_prev   <= 1'b1;
            r_state     <= uart_pkg::RX_IDLE;
            r_clk_count <= '0;
            r_bit_index <= '0;
            o_rx_valid  <= 1'b0;
            o_rx_word   <= '0;
        end else begin
            r_sync      <= {r_sync[SYNC_STAGES-2:0], i_rx};
            r_rx_prev   <= w_rx;
            r_state     <= w_next_state;
            r_clk_count <= w_clk_count_next;
            r_bit_index <= w_bit_index_next;
            o_rx_valid  <= w_stop_sample;
            if (w_stop_sample) begin
                o_rx_word.data        <= r_shift;
                o_rx_word.frame_error <= !w_rx;
            end
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge i_clk) begin
        if (w_data_sample) begin
            r_shift <= {w_rx, r_shift[7:1]};
        end
    end

    // One word per frame, never a stretched strobe
    a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rx_valid |=> !o_rx_valid);

    a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        r_state inside {uart_pkg::RX_IDLE, uart_pkg::RX_START,
                        uart_pkg::RX_DATA, uart_pkg::RX_STOP});

endmodule : uart_rx

//--- hw/uart_core.sv
// UART core top level
`timescale 1ns/100ps

`include "uart_config.svh"

module uart_core (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    // Byte input
    input  logic [7:0]              i_tx_data,
    input  logic                    i_tx_valid,
    output logic                    o_tx_ready,
    // Serial line
    output logic                    o_tx,
    input  logic                    i_rx,
    // Received words
    output logic                    o_rx_valid,
    output uart_pkg::uart_rx_word_t o_rx_word
);

    // Both directions run from the same bit timing
    uart_tx #(
        .CLKS_PER_BIT (`UART_CLKS_PER_BIT)
    ) u_tx (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_tx_data  (i_tx_data),
        .i_tx_valid (i_tx_valid),
        .o_tx_ready (o_tx_ready),
        .o_tx       (o_tx)
    );

    uart_rx #(
        .CLKS_PER_BIT (`UART_CLKS_PER_BIT)
    ) u_rx (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rx       (i_rx),
        .o_rx_valid (o_rx_valid),
        .o_rx_word  (o_rx_word)
    );

endmodule : uart_core

//--- bench/tb_uart_core.sv
// UART core testbench
`timescale 1ns/100ps

`include "uart_config.svh"

module tb_uart_core;

    localparam int CLK_PERIOD = 4;
    localparam int N          = `UART_CLKS_PER_BIT;
    localparam int RX_DELAY   = `UART_SYNC_STAGES + N / 2 + 9 * N;
    localparam int NUM_FIXED  = 7;
    localparam int NUM_ROWS   = NUM_FIXED + 6;
    localparam int TIMEOUT_NS = (NUM_ROWS + 4) * 12 * N * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h6e632285;

    // One stimulus row and the word it should produce
    typedef struct packed {
        logic                    loopback;
        logic [7:0]              data;
        logic                    stop_level;
        logic [7:0]              start_len;
        logic                    expect_word;
        uart_pkg::uart_rx_word_t expected;
    } row_t;

    logic                    clk;
    logic                    rst_n;
    logic [7:0]              tx_data;
    logic                    tx_valid;
    logic                    tx_ready;
    logic                    tx_line;
    logic                    rx_line;
    logic                    rx_valid;
    uart_pkg::uart_rx_word_t rx_word;
    logic                    loopback_mode;
    logic                    drive_rx;
    int                      cycle = 0;
    int                      line_fall_cycle;
    row_t                    rows [NUM_ROWS];
    uart_pkg::uart_rx_word_t rx_words [$];
    int                      rx_cycles [$];

    uart_core i_dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_tx_data  (tx_data),
        .i_tx_valid (tx_valid),
        .o_tx_ready (tx_ready),
        .o_tx       (tx_line),
        .i_rx       (rx_line),
        .o_rx_valid (rx_valid),
        .o_rx_word  (rx_word)
    );

    // Receiver listens to its own transmitter or to the bit-banged line
    assign rx_line = loopback_mode ? tx_line : drive_rx;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Collect every received word with the cycle it showed up in
    always @(posedge clk) begin
        if (rx_valid) begin
            rx_words.push_back(rx_word);
            rx_cycles.push_back(cycle);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the tests did not finish in time", TIMEOUT_NS);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s actual %0h expected %0h", $time, name, actual,
                     expected);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Start bit, data LSB first, then stop bit
    function automatic logic frame_bit(input logic [7:0] data, input int index);
        if (index == 0) begin
            return 1'b0;
        end
        if (index == 9) begin
            return 1'b1;
        end
        return data[index - 1];
    endfunction

    function automatic row_t make_row(input logic loopback, input logic [7:0] data,
                                      input logic stop_level, input int start_len);
        row_t r;
        r.loopback             = loopback;
        r.data                 = data;
        r.stop_level           = stop_level;
        r.start_len            = 8'(start_len);
        // A start shorter than half a bit is a glitch
        r.expect_word          = (start_len >= N / 2);
        r.expected.data        = data;
        r.expected.frame_error = !stop_level;
        return r;
    endfunction

    task automatic send_byte(input logic [7:0] data, input logic hold_next,
                             input logic [7:0] next_data);
        tx_data  = data;
        tx_valid = 1'b1;
        while (!tx_ready) begin
            next_cycle();
        end
        next_cycle();
        // Next byte waits on valid while this frame is on the line
        tx_valid        = hold_next;
        tx_data         = hold_next ? next_data : ~data;
        line_fall_cycle = cycle;
        for (int j = 0; j < 10 * N; j++) begin
            check_value("o_tx_ready", 32'(tx_ready), 32'd0);
            if (j % N == N / 2) begin
                check_value("o_tx", 32'(tx_line), 32'(frame_bit(data, j / N)));
            end
            next_cycle();
        end
        check_value("o_tx_ready", 32'(tx_ready), 32'd1);
    endtask

    task automatic drive_line(input logic [7:0] data, input logic stop_level,
                              input int start_len);
        drive_rx        = 1'b0;
        line_fall_cycle = cycle;
        repeat (start_len) next_cycle();
        if (start_len < N) begin
            drive_rx = 1'b1;
            // Idle for a whole frame so a false start would have delivered a word
            repeat (11 * N) next_cycle();
        end else begin
            for (int i = 0; i < 8; i++) begin
                drive_rx = data[i];
                repeat (N) next_cycle();
            end
            drive_rx = stop_level;
            repeat (N) next_cycle();
            drive_rx = 1'b1;
            repeat (N) next_cycle();
        end
    endtask

    task automatic check_received(input row_t row);
        uart_pkg::uart_rx_word_t word;
        int                      delay;
        if (row.expect_word) begin
            check_value("rx word count", 32'(rx_words.size()), 32'd1);
            word  = rx_words.pop_front();
            delay = rx_cycles.pop_front() - line_fall_cycle;
            check_value("o_rx_word.data", 32'(word.data), 32'(row.expected.data));
            check_value("o_rx_word.frame_error", 32'(word.frame_error),
                        32'(row.expected.frame_error));
            if (delay < RX_DELAY - 1 || delay > RX_DELAY + 1) begin
                check_value("o_rx_valid delay", 32'(delay), 32'(RX_DELAY));
            end
        end else begin
            check_value("rx word count", 32'(rx_words.size()), 32'd0);
        end
    endtask

    initial begin
        logic [31:0] lcg_state;
        logic        hold;
        clk           = 1'b0;
        rst_n         = 1'b0;
        tx_data       = 8'h00;
        tx_valid      = 1'b0;
        loopback_mode = 1'b1;
        drive_rx      = 1'b1;

        rows[0] = make_row(1'b1, 8'h00, 1'b1, N);
        rows[1] = make_row(1'b1, 8'hff, 1'b1, N);
        rows[2] = make_row(1'b1, 8'h55, 1'b1, N);
        rows[3] = make_row(1'b1, 8'ha5, 1'b1, N);
        rows[4] = make_row(1'b0, 8'h3c, 1'b0, N);
        rows[5] = make_row(1'b0, 8'h00, 1'b1, 2);
        rows[6] = make_row(1'b0, 8'hc3, 1'b1, N);
        lcg_state = SEED;
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            lcg_state = lcg_next(lcg_state);
            rows[r]   = make_row(1'b1, lcg_state[23:16], 1'b1, N);
        end

        repeat (3) next_cycle();
        check_value("o_tx", 32'(tx_line), 32'd1);
        check_value("o_tx_ready", 32'(tx_ready), 32'd1);
        check_value("o_rx_valid", 32'(rx_valid), 32'd0);
        rst_n = 1'b1;
        next_cycle();
        check_value("o_tx", 32'(tx_line), 32'd1);
        check_value("o_tx_ready", 32'(tx_ready), 32'd1);
        check_value("o_rx_valid", 32'(rx_valid), 32'd0);
        check_value("o_rx_word", 32'(rx_word), 32'd0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            loopback_mode = rows[r].loopback;
            if (rows[r].loopback) begin
                hold = (r + 1 < NUM_ROWS) && rows[r + 1].loopback;
                send_byte(rows[r].data, hold, hold ? rows[r + 1].data : 8'h00);
            end else begin
                drive_line(rows[r].data, rows[r].stop_level, int'(rows[r].start_len));
            end
            check_received(rows[r]);
        end

        // Nothing left queued in either direction
        repeat (12 * N) next_cycle();
        check_value("rx word count", 32'(rx_words.size()), 32'd0);
        check_value("o_tx_ready", 32'(tx_ready), 32'd1);
        check_value("o_tx", 32'(tx_line), 32'd1);
        $display("All tests passed!");
        $finish;
    end

endmodule : tb_uart_core

//--- project.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_core.sv
bench/tb_uart_core.sv

//--- Makefile
TOP = tb_uart_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
